//--- logic/md_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module md_divider (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 div_go,
    input  wire                 div_signed,
    input  wire [`MD_XLEN-1:0]  div_a,
    input  wire [`MD_XLEN-1:0]  div_b,
    input  wire                 div_take,
    output logic                div_busy,
    output logic                div_done,
    output logic [`MD_XLEN-1:0] div_rem,
    output logic [`MD_XLEN-1:0] div_quo
);
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(`MD_DIV_STEPS);

    div_state_e          state_q;
    logic [CNT_W-1:0]    step_q;
    logic                last_step;
    logic                by_zero;

    logic                a_neg;
    logic                b_neg;
    logic [`MD_XLEN-1:0] abs_a;
    logic [`MD_XLEN-1:0] abs_b;

    logic [`MD_XLEN-1:0] rem_q;
    logic [`MD_XLEN-1:0] quo_q;
    logic [`MD_XLEN-1:0] dvs_q;
    logic                neg_quo_q;
    logic                neg_rem_q;
    logic [`MD_XLEN:0]   shifted;
    logic [`MD_XLEN:0]   trial;

    assign by_zero   = (div_b == '0);
    assign last_step = (step_q == CNT_W'(`MD_DIV_STEPS - 1));

    // magnitudes for the signed case
    assign a_neg = div_signed && div_a[`MD_XLEN-1];
    assign b_neg = div_signed && div_b[`MD_XLEN-1];
    assign abs_a = a_neg ? -div_a : div_a;
    assign abs_b = b_neg ? -div_b : div_b;

    // bring down the next dividend bit and try the subtraction
    assign shifted = {rem_q, quo_q[`MD_XLEN-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    step_q <= '0;
                    if (div_go) begin
                        state_q <= by_zero ? DIV_DONE : DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + CNT_W'(1);
                    if (last_step) begin
                        state_q <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state_q <= DIV_DONE;
                end
                DIV_DONE: begin
                    if (div_take) begin
                        state_q <= DIV_IDLE;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                if (div_go) begin
                    dvs_q     <= abs_b;
                    // quotient takes the xor of the signs, remainder the dividend sign
                    neg_quo_q <= a_neg ^ b_neg;
                    neg_rem_q <= a_neg;
                    if (by_zero) begin
                        quo_q <= '1;
                        rem_q <= div_a;
                    end else begin
                        quo_q <= abs_a;
                        rem_q <= '0;
                    end
                end
            end
            DIV_RUN: begin
                if (!trial[`MD_XLEN]) begin
                    rem_q <= trial[`MD_XLEN-1:0];
                    quo_q <= {quo_q[`MD_XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[`MD_XLEN-1:0];
                    quo_q <= {quo_q[`MD_XLEN-2:0], 1'b0};
                end
            end
            DIV_FIX: begin
                if (neg_quo_q) begin
                    quo_q <= -quo_q;
                end
                if (neg_rem_q) begin
                    rem_q <= -rem_q;
                end
            end
            default: begin
                rem_q <= rem_q;
            end
        endcase
    end

    // busy already in the go cycle so nothing else slips in
    assign div_busy = div_go || (state_q != DIV_IDLE);
    assign div_done = (state_q == DIV_DONE);
    assign div_rem  = rem_q;
    assign div_quo  = quo_q;

endmodule

`default_nettype wire

//--- logic/md_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module md_issue_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_valid,
    input  var muldiv_pkg::md_op_e in_op,
    input  wire [`MD_XLEN-1:0]   in_src1,
    input  wire [`MD_XLEN-1:0]   in_src2,
    input  wire                  div_busy,
    input  wire                  advance,
    input  wire                  result_take,
    output logic                 in_ready,
    output logic                 mul_go,
    output logic                 mul_signed,
    output logic [`MD_XLEN-1:0]  mul_a,
    output logic [`MD_XLEN-1:0]  mul_b,
    output logic                 div_go,
    output logic                 div_signed,
    output logic [`MD_XLEN-1:0]  div_a,
    output logic [`MD_XLEN-1:0]  div_b
);
    import muldiv_pkg::*;

    // issue reg, two multiply stages and the output register
    localparam int CNT_W = $clog2(`MD_MUL_DEPTH + 3);

    logic               op_is_div;
    logic               accept;
    logic               mul_stalled;
    logic [CNT_W-1:0]   mul_cnt;
    logic               div_pending;
    logic               cnt_inc;
    logic               cnt_dec;
    logic [`MD_XLEN-1:0] src1_q;
    logic [`MD_XLEN-1:0] src2_q;
    logic               signed_q;

    assign op_is_div   = (in_op == MD_DIV) || (in_op == MD_DIVU);
    // multiply waiting in the issue register while the pipeline is frozen
    assign mul_stalled = mul_go && !advance;

    // a divide may only start once every earlier result has left
    assign in_ready = !div_busy && !mul_stalled
                   && !(op_is_div && ((mul_cnt != '0) || div_pending));
    assign accept   = in_valid && in_ready;

    assign cnt_inc = accept && !op_is_div;
    // the divide result always sits ahead of any later multiply
    assign cnt_dec = result_take && !div_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_go      <= 1'b0;
            div_go      <= 1'b0;
            div_pending <= 1'b0;
            mul_cnt     <= '0;
        end else begin
            if (!mul_stalled) begin
                mul_go <= cnt_inc;
            end
            div_go <= accept && op_is_div;
            if (accept && op_is_div) begin
                div_pending <= 1'b1;
            end else if (result_take) begin
                div_pending <= 1'b0;
            end
            case ({cnt_inc, cnt_dec})
                2'b10:   mul_cnt <= mul_cnt + CNT_W'(1);
                2'b01:   mul_cnt <= mul_cnt - CNT_W'(1);
                default: mul_cnt <= mul_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src1_q   <= in_src1;
            src2_q   <= in_src2;
            signed_q <= (in_op == MD_MULT) || (in_op == MD_DIV);
        end
    end

    // both paths read the same operand register
    assign mul_signed = signed_q;
    assign mul_a      = src1_q;
    assign mul_b      = src2_q;
    assign div_signed = signed_q;
    assign div_a      = src1_q;
    assign div_b      = src2_q;

endmodule

`default_nettype wire

//--- logic/md_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module md_multiplier (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 advance,
    input  wire                 mul_go,
    input  wire                 mul_signed,
    input  wire [`MD_XLEN-1:0]  mul_a,
    input  wire [`MD_XLEN-1:0]  mul_b,
    output logic                mul_done,
    output logic [`MD_XLEN-1:0] mul_hi,
    output logic [`MD_XLEN-1:0] mul_lo
);
    // one extra bit lets a single signed multiply cover both modes
    localparam int OW = `MD_XLEN + 1;
    localparam int PW = 2 * OW;

    logic                    s1_valid;
    logic signed [OW-1:0]    s1_a;
    logic signed [OW-1:0]    s1_b;
    logic signed [PW-1:0]    prod_full;
    logic                    s2_valid;
    logic [2*`MD_XLEN-1:0]   s2_prod;

    assign prod_full = PW'(s1_a) * PW'(s1_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= mul_go;
            s2_valid <= s1_valid;
        end
    end

    // whole pipeline freezes when the output register cannot take more
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_a    <= {mul_signed & mul_a[`MD_XLEN-1], mul_a};
            s1_b    <= {mul_signed & mul_b[`MD_XLEN-1], mul_b};
            s2_prod <= prod_full[2*`MD_XLEN-1:0];
        end
    end

    assign mul_done = s2_valid;
    assign mul_hi   = s2_prod[2*`MD_XLEN-1:`MD_XLEN];
    assign mul_lo   = s2_prod[`MD_XLEN-1:0];

endmodule

`default_nettype wire

//--- logic/md_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module md_result_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 mul_done,
    input  wire [`MD_XLEN-1:0]  mul_hi,
    input  wire [`MD_XLEN-1:0]  mul_lo,
    input  wire                 div_done,
    input  wire [`MD_XLEN-1:0]  div_rem,
    input  wire [`MD_XLEN-1:0]  div_quo,
    input  wire                 out_ready,
    output logic                advance,
    output logic                div_take,
    output logic                result_take,
    output logic                out_valid,
    output logic [`MD_XLEN-1:0] out_hi,
    output logic [`MD_XLEN-1:0] out_lo
);
    logic                valid_q;
    logic [`MD_XLEN-1:0] hi_q;
    logic [`MD_XLEN-1:0] lo_q;
    logic                load_mul;

    // output register is free or leaves this cycle
    assign advance     = !valid_q || out_ready;
    assign result_take = valid_q && out_ready;

    // issue ordering keeps the two sources from finishing together
    assign load_mul = advance && mul_done;
    assign div_take = advance && div_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= mul_done || div_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_mul) begin
            hi_q <= mul_hi;
            lo_q <= mul_lo;
        end else if (div_take) begin
            // remainder high, quotient low
            hi_q <= div_rem;
            lo_q <= div_quo;
        end
    end

    assign out_valid = valid_q;
    assign out_hi    = hi_q;
    assign out_lo    = lo_q;

endmodule

`default_nettype wire

//--- logic/muldiv_defs.svh
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// operand width, results are twice this
`define MD_XLEN 32

// one quotient bit per restoring step
`define MD_DIV_STEPS `MD_XLEN

// register stages inside the multiplier
`define MD_MUL_DEPTH 2

`endif

//--- logic/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // operation codes seen at the unit input
    typedef enum logic [1:0] {
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU
    } md_op_e;

    // divider sequencing
    // run covers the restoring iterations, fix applies the result signs
    typedef enum logic [2:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX,
        DIV_DONE
    } div_state_e;

endpackage

`default_nettype wire

//--- logic/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  var muldiv_pkg::md_op_e in_op,
    input  wire [`MD_XLEN-1:0]   in_src1,
    input  wire [`MD_XLEN-1:0]   in_src2,
    output logic                 out_valid,
    input  wire                  out_ready,
    output logic [`MD_XLEN-1:0]  out_hi,
    output logic [`MD_XLEN-1:0]  out_lo
);
    logic                mul_go;
    logic                mul_signed;
    logic [`MD_XLEN-1:0] mul_a;
    logic [`MD_XLEN-1:0] mul_b;
    logic                mul_done;
    logic [`MD_XLEN-1:0] mul_hi;
    logic [`MD_XLEN-1:0] mul_lo;

    logic                div_go;
    logic                div_signed;
    logic [`MD_XLEN-1:0] div_a;
    logic [`MD_XLEN-1:0] div_b;
    logic                div_busy;
    logic                div_done;
    logic [`MD_XLEN-1:0] div_rem;
    logic [`MD_XLEN-1:0] div_quo;
    logic                div_take;

    logic                advance;
    logic                result_take;

    md_issue_stage u_issue (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_op(in_op), .in_src1(in_src1), .in_src2(in_src2),
        .div_busy(div_busy), .advance(advance), .result_take(result_take),
        .in_ready(in_ready),
        .mul_go(mul_go), .mul_signed(mul_signed), .mul_a(mul_a), .mul_b(mul_b),
        .div_go(div_go), .div_signed(div_signed), .div_a(div_a), .div_b(div_b)
    );

    md_multiplier u_mul (
        .clk(clk), .rst(rst), .advance(advance),
        .mul_go(mul_go), .mul_signed(mul_signed), .mul_a(mul_a), .mul_b(mul_b),
        .mul_done(mul_done), .mul_hi(mul_hi), .mul_lo(mul_lo)
    );

    md_divider u_div (
        .clk(clk), .rst(rst),
        .div_go(div_go), .div_signed(div_signed), .div_a(div_a), .div_b(div_b),
        .div_take(div_take), .div_busy(div_busy), .div_done(div_done),
        .div_rem(div_rem), .div_quo(div_quo)
    );

    md_result_stage u_result (
        .clk(clk), .rst(rst),
        .mul_done(mul_done), .mul_hi(mul_hi), .mul_lo(mul_lo),
        .div_done(div_done), .div_rem(div_rem), .div_quo(div_quo),
        .out_ready(out_ready), .advance(advance), .div_take(div_take),
        .result_take(result_take),
        .out_valid(out_valid), .out_hi(out_hi), .out_lo(out_lo)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the run by the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module muldiv_tb -o muldiv_sim \
    && ./obj_dir/muldiv_sim | tee /dev/stderr | grep -qx "TEST RESULT: PASS" \
    && exit 0 \
    || { echo "simulation did not pass"; exit 1; }

//--- sim.f
+incdir+logic
+incdir+tb
logic/muldiv_pkg.sv
logic/md_issue_stage.sv
logic/md_multiplier.sv
logic/md_divider.sv
logic/md_result_stage.sv
logic/muldiv_top.sv
tb/muldiv_tb.sv

//--- tb/muldiv_tb_checks.svh
`ifndef MULDIV_TB_CHECKS_SVH
`define MULDIV_TB_CHECKS_SVH

// product halves, high word then low word
task automatic check_mul_result(
    input md_op_e              op,
    input logic [`MD_XLEN-1:0] exp_hi,
    input logic [`MD_XLEN-1:0] exp_lo,
    input logic [`MD_XLEN-1:0] act_hi,
    input logic [`MD_XLEN-1:0] act_lo
);
    if (act_hi !== exp_hi) begin
        $display("Error: out_hi for %s expected %h, got %h", op.name(), exp_hi, act_hi);
        abort_run("multiply high word mismatch");
    end
    if (act_lo !== exp_lo) begin
        $display("Error: out_lo for %s expected %h, got %h", op.name(), exp_lo, act_lo);
        abort_run("multiply low word mismatch");
    end
endtask

// remainder sits in the high word, quotient in the low word
task automatic check_div_result(
    input md_op_e              op,
    input logic [`MD_XLEN-1:0] exp_rem,
    input logic [`MD_XLEN-1:0] exp_quo,
    input logic [`MD_XLEN-1:0] act_hi,
    input logic [`MD_XLEN-1:0] act_lo
);
    if (act_hi !== exp_rem) begin
        $display("Error: out_hi (remainder) for %s expected %h, got %h",
                 op.name(), exp_rem, act_hi);
        abort_run("divide remainder mismatch");
    end
    if (act_lo !== exp_quo) begin
        $display("Error: out_lo (quotient) for %s expected %h, got %h",
                 op.name(), exp_quo, act_lo);
        abort_run("divide quotient mismatch");
    end
endtask

`endif

//--- tb/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_tb;
    import muldiv_pkg::*;

    localparam int num_random  = 300;
    localparam int issue_limit = 600;
    localparam int drain_limit = 4000;

    // corner operands for the multiply sweep
    localparam logic [`MD_XLEN-1:0] corner_vals [6] = '{
        32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
        32'h8000_0000, 32'h7fff_ffff, 32'h1234_5678
    };

    // dividend and divisor pairs, every sign mix plus the special cases
    localparam logic [`MD_XLEN-1:0] div_a_vals [12] = '{
        32'h0000_0064, 32'hffff_ff9c, 32'h0000_0064, 32'hffff_ff9c,
        32'h0000_0003, 32'hffff_fffd, 32'h8000_0000, 32'h0000_0005,
        32'hffff_fffb, 32'h0000_0000, 32'h7fff_ffff, 32'hffff_ffff
    };
    localparam logic [`MD_XLEN-1:0] div_b_vals [12] = '{
        32'h0000_0007, 32'h0000_0007, 32'hffff_fff9, 32'hffff_fff9,
        32'h0000_000a, 32'h0000_000a, 32'hffff_ffff, 32'h0000_0000,
        32'h0000_0000, 32'h0000_0005, 32'h7fff_ffff, 32'h0000_0001
    };

    typedef struct packed {
        md_op_e              op;
        logic [`MD_XLEN-1:0] hi;
        logic [`MD_XLEN-1:0] lo;
    } expect_t;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    md_op_e              in_op;
    logic [`MD_XLEN-1:0] in_src1;
    logic [`MD_XLEN-1:0] in_src2;
    logic                out_valid;
    logic                out_ready;
    logic [`MD_XLEN-1:0] out_hi;
    logic [`MD_XLEN-1:0] out_lo;

    expect_t             expect_q[$];
    logic                ready_random;
    logic                held;
    logic [`MD_XLEN-1:0] held_hi;
    logic [`MD_XLEN-1:0] held_lo;

    md_op_e              rnd_op [num_random];
    logic [`MD_XLEN-1:0] rnd_a [num_random];
    logic [`MD_XLEN-1:0] rnd_b [num_random];

    muldiv_top UUT (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_src1(in_src1), .in_src2(in_src2),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_hi(out_hi), .out_lo(out_lo)
    );

    task automatic abort_run(input string reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, reason);
    endtask

    `include "muldiv_tb_checks.svh"

    // {hi, lo} as the unit should return it
    function automatic logic [2*`MD_XLEN-1:0] expected_result(
        input md_op_e op,
        input logic [`MD_XLEN-1:0] a,
        input logic [`MD_XLEN-1:0] b
    );
        longint          sa;
        longint          sb;
        logic [63:0]     ua;
        logic [63:0]     ub;
        int              da;
        int              db;
        int              q;
        int              r;
        case (op)
            MD_MULT: begin
                sa = longint'(signed'(a));
                sb = longint'(signed'(b));
                return sa * sb;
            end
            MD_MULTU: begin
                ua = {32'h0, a};
                ub = {32'h0, b};
                return ua * ub;
            end
            MD_DIV: begin
                if (b == '0) begin
                    return {a, 32'hffff_ffff};
                end
                // overflow case wraps back to the dividend
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    return {32'h0, a};
                end
                da = signed'(a);
                db = signed'(b);
                q  = da / db;
                r  = da % db;
                return {r, q};
            end
            default: begin
                if (b == '0) begin
                    return {a, 32'hffff_ffff};
                end
                return {a % b, a / b};
            end
        endcase
    endfunction

    // corner values show up often, including zero divisors
    function automatic logic [`MD_XLEN-1:0] random_operand();
        case ($urandom_range(7, 0))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'($urandom_range(15, 0));
            default: return $urandom();
        endcase
    endfunction

    task automatic compare_result(input expect_t e, input logic [`MD_XLEN-1:0] hi,
                                  input logic [`MD_XLEN-1:0] lo);
        if (e.op == MD_MULT || e.op == MD_MULTU) begin
            check_mul_result(e.op, e.hi, e.lo, hi, lo);
        end else begin
            check_div_result(e.op, e.hi, e.lo, hi, lo);
        end
    endtask

    // entered and left on a falling edge
    task automatic issue_op(input md_op_e op, input logic [`MD_XLEN-1:0] a,
                            input logic [`MD_XLEN-1:0] b);
        int                      waited;
        div_state_e              dstate;
        expect_t                 e;
        logic [2*`MD_XLEN-1:0]   res;
        in_valid = 1'b1;
        in_op    = op;
        in_src1  = a;
        in_src2  = b;
        waited   = 0;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > issue_limit) begin
                dstate = UUT.u_div.state_q;
                abort_run($sformatf("no input handshake within %0d cycles, divider in %s",
                                    issue_limit, dstate.name()));
            end
            @(posedge clk);
        end
        res  = expected_result(op, a, b);
        e.op = op;
        e.hi = res[2*`MD_XLEN-1:`MD_XLEN];
        e.lo = res[`MD_XLEN-1:0];
        expect_q.push_back(e);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0) begin
            waited++;
            if (waited > drain_limit) begin
                abort_run($sformatf("%0d results still outstanding after %0d cycles",
                                    expect_q.size(), drain_limit));
            end
            @(negedge clk);
        end
    endtask

    task automatic run_random_stream();
        for (int k = 0; k < num_random; k++) begin
            issue_op(rnd_op[k], rnd_a[k], rnd_b[k]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // back-pressure source
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (ready_random) begin
                out_ready = 1'($urandom_range(1, 0));
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // output side: ordering, values and hold under back-pressure
    initial begin
        expect_t head;
        held = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                held = 1'b0;
            end else begin
                if (out_valid && expect_q.size() == 0) begin
                    abort_run("out_valid is high with no operation outstanding");
                end
                if (held) begin
                    if (!out_valid) begin
                        abort_run("out_valid dropped before the result was accepted");
                    end
                    head = expect_q[0];
                    head.hi = held_hi;
                    head.lo = held_lo;
                    compare_result(head, out_hi, out_lo);
                end
                if (out_valid && out_ready) begin
                    head = expect_q.pop_front();
                    compare_result(head, out_hi, out_lo);
                end
                held    = out_valid && !out_ready;
                held_hi = out_hi;
                held_lo = out_lo;
            end
        end
    end

    initial begin
        int          seed_ret;
        logic [1:0]  op_bits;
        seed_ret     = $urandom(32'h7d00);
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_op        = MD_MULT;
        in_src1      = '0;
        in_src2      = '0;
        ready_random = 1'b0;

        // one stream, replayed with and without back-pressure
        for (int k = 0; k < num_random; k++) begin
            op_bits  = 2'($urandom_range(3, 0));
            rnd_op[k] = md_op_e'(op_bits);
            rnd_a[k]  = random_operand();
            rnd_b[k]  = random_operand();
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (out_valid !== 1'b0) begin
            $display("Error: out_valid after reset expected %h, got %h", 1'b0, out_valid);
            abort_run("out_valid set after reset");
        end
        if (in_ready !== 1'b1) begin
            $display("Error: in_ready after reset expected %h, got %h", 1'b1, in_ready);
            abort_run("in_ready low after reset");
        end
        @(negedge clk);

        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                issue_op(MD_MULT, corner_vals[i], corner_vals[j]);
                issue_op(MD_MULTU, corner_vals[i], corner_vals[j]);
            end
        end
        for (int i = 0; i < 12; i++) begin
            issue_op(MD_DIV, div_a_vals[i], div_b_vals[i]);
            issue_op(MD_DIVU, div_a_vals[i], div_b_vals[i]);
        end
        wait_for_drain();

        run_random_stream();
        wait_for_drain();

        @(posedge clk);
        ready_random = 1'b1;
        @(negedge clk);
        run_random_stream();
        wait_for_drain();
        @(posedge clk);
        ready_random = 1'b0;
        @(negedge clk);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
